/* hw/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int opcode_w  = 7;
    localparam int reg_idx_w = 3;
    localparam int imm_w     = 19;
    localparam int unused_w  = 16;

    typedef enum logic [opcode_w-1:0] {
        op_add   = 7'h01,
        op_sub   = 7'h02,
        op_and   = 7'h03,
        op_or    = 7'h04,
        op_xor   = 7'h05,
        op_addi  = 7'h08,
        op_load  = 7'h09,
        op_store = 7'h0a,
        op_bflag = 7'h10,
        op_jump  = 7'h11,
        op_halt  = 7'h7f
    } opcode_e;

    // register form with rb in 15..13
    typedef struct packed {
        logic [unused_w-1:0]  unused;
        logic [reg_idx_w-1:0] rb;
        logic [reg_idx_w-1:0] ra;
        logic [reg_idx_w-1:0] rd;
        opcode_e              opcode;
    } instr_reg_t;

    // immediate form with imm on top of rb
    typedef struct packed {
        logic [imm_w-1:0]     imm;
        logic [reg_idx_w-1:0] ra;
        logic [reg_idx_w-1:0] rd;
        opcode_e              opcode;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

endpackage

/* hw/cpu_core_pkg.sv */
package cpu_core_pkg;

    localparam int word_w   = 32;
    localparam int num_regs = 8;

    localparam logic [word_w-1:0] reset_pc = '0;

    // fetch, execute, optional memory phase
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory
    } cpu_state_e;

endpackage

/* hw/cpu_control.sv */
module cpu_control
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst,
    input  logic [word_w-1:0]       rdata,
    input  logic                    ra_flag,
    output logic [reg_idx_w-1:0]    ra_sel,
    output logic [reg_idx_w-1:0]    rb_sel,
    output logic [reg_idx_w-1:0]    rd_sel,
    output opcode_e                 alu_op,
    output logic signed [imm_w-1:0] imm,
    output logic                    reg_we,
    output logic                    flag_we,
    output logic                    load_sel,
    output logic                    pc_inc,
    output logic                    pc_branch,
    output logic                    pc_jump,
    output logic                    ea_we,
    output logic                    addr_sel,
    output logic                    rw,
    output logic                    halted
);

    cpu_state_e state;
    cpu_state_e next_state;
    instr_t     ir;
    opcode_e    opcode;

    assign opcode = ir.r.opcode;
    assign alu_op = opcode;
    assign ra_sel = ir.i.ra;
    assign rd_sel = ir.i.rd;
    assign rb_sel = ir.r.rb;
    assign imm    = ir.i.imm;
    assign halted = (state == st_execute) && (opcode == op_halt);

    always_ff @(posedge clock)
    begin
        if (rst)
            state <= st_fetch;
        else
            state <= next_state;
    end

    always_ff @(posedge clock)
    begin
        if (state == st_fetch)
            ir <= rdata;
    end

    always_comb
    begin
        next_state = state;
        reg_we     = 1'b0;
        flag_we    = 1'b0;
        load_sel   = 1'b0;
        pc_inc     = 1'b0;
        pc_branch  = 1'b0;
        pc_jump    = 1'b0;
        ea_we      = 1'b0;
        addr_sel   = 1'b0;
        rw         = 1'b1;
        case (state)
            st_fetch:
                next_state = st_execute;
            st_execute:
            begin
                next_state = st_fetch;
                case (opcode)
                    op_add, op_sub, op_and, op_or, op_xor, op_addi:
                    begin
                        reg_we  = 1'b1;
                        flag_we = 1'b1;
                        pc_inc  = 1'b1;
                    end
                    op_load, op_store:
                    begin
                        ea_we      = 1'b1;
                        next_state = st_memory;
                    end
                    op_bflag:
                    begin
                        pc_branch = ra_flag;
                        pc_inc    = !ra_flag;
                    end
                    op_jump:
                        pc_jump = 1'b1;
                    op_halt:
                        next_state = st_execute;
                    // unknown words act as a nop
                    default:
                        pc_inc = 1'b1;
                endcase
            end
            st_memory:
            begin
                addr_sel   = 1'b1;
                pc_inc     = 1'b1;
                next_state = st_fetch;
                if (opcode == op_store)
                begin
                    rw = 1'b0;
                end
                else
                begin
                    reg_we   = 1'b1;
                    flag_we  = 1'b1;
                    load_sel = 1'b1;
                end
            end
            default:
                next_state = st_fetch;
        endcase
    end

    // a write needs the address latched one cycle before
    store_only_in_memory: assert property (@(posedge clock) disable iff (rst)
        !rw |-> state == st_memory && opcode == op_store && $past(ea_we));

    branch_exclusive: assert property (@(posedge clock) disable iff (rst)
        pc_branch |-> !reg_we && !pc_jump);

    known_opcode: assert property (@(posedge clock) disable iff (rst)
        state == st_execute |-> opcode inside {op_add, op_sub, op_and, op_or, op_xor,
            op_addi, op_load, op_store, op_bflag, op_jump, op_halt});

endmodule

/* hw/cpu_reg_file.sv */
module cpu_reg_file
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst,
    input  logic [reg_idx_w-1:0] ra_sel,
    input  logic [reg_idx_w-1:0] rb_sel,
    input  logic [reg_idx_w-1:0] rd_sel,
    input  logic                 reg_we,
    input  logic                 flag_we,
    input  logic                 load_sel,
    input  logic [word_w-1:0]    result,
    input  logic [word_w-1:0]    rdata,
    input  logic                 flag_in,
    output logic [word_w-1:0]    ra_data,
    output logic [word_w-1:0]    rb_data,
    output logic [word_w-1:0]    rd_data,
    output logic                 ra_flag
);

    logic [word_w-1:0] regs [num_regs];
    logic [num_regs-1:0] flags;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            regs  <= '{default: '0};
            flags <= '0;
        end
        else
        begin
            if (reg_we)
                regs[rd_sel] <= load_sel ? rdata : result;
            // loaded words carry no flag
            if (flag_we)
                flags[rd_sel] <= load_sel ? 1'b0 : flag_in;
        end
    end

    assign ra_data = regs[ra_sel];
    assign rb_data = regs[rb_sel];
    assign rd_data = regs[rd_sel];
    assign ra_flag = flags[ra_sel];

    write_index_known: assert property (@(posedge clock) disable iff (rst)
        reg_we |-> !$isunknown(rd_sel));

endmodule

/* hw/cpu_alu.sv */
module cpu_alu
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  opcode_e                 alu_op,
    input  logic [word_w-1:0]       ra_data,
    input  logic [word_w-1:0]       rb_data,
    input  logic signed [imm_w-1:0] imm,
    input  logic [word_w-1:0]       pc,
    output logic [word_w-1:0]       result,
    output logic [word_w-1:0]       target,
    output logic                    flag_out
);

    logic [word_w-1:0] imm_ext;
    logic [word_w-1:0] operand_b;
    logic [word_w:0]   sum;
    logic [word_w:0]   diff;
    logic [word_w-1:0] logic_res;
    logic              reg_form;

    assign imm_ext  = word_w'(imm);
    assign reg_form = alu_op inside {op_add, op_sub, op_and, op_or, op_xor};
    assign operand_b = reg_form ? rb_data : imm_ext;

    // extra top bit holds carry or borrow
    assign sum  = {1'b0, ra_data} + {1'b0, operand_b};
    assign diff = {1'b0, ra_data} - {1'b0, operand_b};

    always_comb
    begin
        case (alu_op)
            op_and:  logic_res = ra_data & operand_b;
            op_or:   logic_res = ra_data | operand_b;
            default: logic_res = ra_data ^ operand_b;
        endcase
    end

    always_comb
    begin
        case (alu_op)
            op_add, op_addi:
            begin
                result   = sum[word_w-1:0];
                flag_out = sum[word_w];
            end
            op_sub:
            begin
                result   = diff[word_w-1:0];
                flag_out = diff[word_w];
            end
            op_and, op_or, op_xor:
            begin
                result   = logic_res;
                flag_out = (logic_res == '0);
            end
            // effective address for load and store
            default:
            begin
                result   = sum[word_w-1:0];
                flag_out = 1'b0;
            end
        endcase
    end

    assign target = pc + imm_ext;

endmodule

/* hw/cpu_pc_unit.sv */
module cpu_pc_unit
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    pc_inc,
    input  logic                    pc_branch,
    input  logic                    pc_jump,
    input  logic                    ea_we,
    input  logic                    addr_sel,
    input  logic [word_w-1:0]       target,
    input  logic [word_w-1:0]       ea_in,
    input  logic signed [imm_w-1:0] imm,
    output logic [word_w-1:0]       pc,
    output logic [word_w-1:0]       address
);

    logic [word_w-1:0] ea;

    always_ff @(posedge clock)
    begin
        if (rst)
            pc <= reset_pc;
        else if (pc_branch)
            pc <= target;
        else if (pc_jump)
            pc <= word_w'(imm);
        else if (pc_inc)
            pc <= pc + 1'b1;
    end

    // effective address for the memory phase
    always_ff @(posedge clock)
    begin
        if (ea_we)
            ea <= ea_in;
    end

    assign address = addr_sel ? ea : pc;

    single_pc_update: assert property (@(posedge clock) disable iff (rst)
        $onehot0({pc_inc, pc_branch, pc_jump}));

endmodule

/* hw/cpu_top.sv */
module cpu_top
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic              clock,
    input  logic              rst,
    input  logic [word_w-1:0] rdata,
    output logic [word_w-1:0] address,
    output logic [word_w-1:0] wdata,
    output logic              rw,
    output logic              halted
);

    logic [reg_idx_w-1:0]    ra_sel;
    logic [reg_idx_w-1:0]    rb_sel;
    logic [reg_idx_w-1:0]    rd_sel;
    opcode_e                 alu_op;
    logic signed [imm_w-1:0] imm;
    logic                    reg_we;
    logic                    flag_we;
    logic                    load_sel;
    logic                    pc_inc;
    logic                    pc_branch;
    logic                    pc_jump;
    logic                    ea_we;
    logic                    addr_sel;
    logic [word_w-1:0]       ra_data;
    logic [word_w-1:0]       rb_data;
    logic                    ra_flag;
    logic [word_w-1:0]       result;
    logic [word_w-1:0]       target;
    logic                    flag_out;
    logic [word_w-1:0]       pc;

    cpu_control u_control (
        .clock     (clock),
        .rst       (rst),
        .rdata     (rdata),
        .ra_flag   (ra_flag),
        .ra_sel    (ra_sel),
        .rb_sel    (rb_sel),
        .rd_sel    (rd_sel),
        .alu_op    (alu_op),
        .imm       (imm),
        .reg_we    (reg_we),
        .flag_we   (flag_we),
        .load_sel  (load_sel),
        .pc_inc    (pc_inc),
        .pc_branch (pc_branch),
        .pc_jump   (pc_jump),
        .ea_we     (ea_we),
        .addr_sel  (addr_sel),
        .rw        (rw),
        .halted    (halted)
    );

    // store data comes straight from rd
    cpu_reg_file u_reg_file (
        .clock    (clock),
        .rst      (rst),
        .ra_sel   (ra_sel),
        .rb_sel   (rb_sel),
        .rd_sel   (rd_sel),
        .reg_we   (reg_we),
        .flag_we  (flag_we),
        .load_sel (load_sel),
        .result   (result),
        .rdata    (rdata),
        .flag_in  (flag_out),
        .ra_data  (ra_data),
        .rb_data  (rb_data),
        .rd_data  (wdata),
        .ra_flag  (ra_flag)
    );

    cpu_alu u_alu (
        .alu_op   (alu_op),
        .ra_data  (ra_data),
        .rb_data  (rb_data),
        .imm      (imm),
        .pc       (pc),
        .result   (result),
        .target   (target),
        .flag_out (flag_out)
    );

    cpu_pc_unit u_pc_unit (
        .clock     (clock),
        .rst       (rst),
        .pc_inc    (pc_inc),
        .pc_branch (pc_branch),
        .pc_jump   (pc_jump),
        .ea_we     (ea_we),
        .addr_sel  (addr_sel),
        .target    (target),
        .ea_in     (result),
        .imm       (imm),
        .pc        (pc),
        .address   (address)
    );

endmodule

/* verif/cpu_tb.sv */
module cpu_tb
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          mem_words    = 256;
    localparam int          reset_cycles = 16;
    localparam int          drive_delay  = 5;
    localparam int          idle_cycles  = 20;
    localparam logic [31:0] rand_seed    = 32'h3be3b510;
    // four resets of 16 cycles and four short programs need well under 400
    localparam int          cycle_limit  = 2000;

    logic              clock;
    logic              rst;
    logic [word_w-1:0] rdata;
    logic [word_w-1:0] address;
    logic [word_w-1:0] wdata;
    logic              rw;
    logic              halted;

    logic [word_w-1:0] mem [mem_words];
    logic [word_w-1:0] prog [$];
    int                cycles = 0;
    int                write_count = 0;

    cpu_top dut (
        .clock   (clock),
        .rst     (rst),
        .rdata   (rdata),
        .address (address),
        .wdata   (wdata),
        .rw      (rw),
        .halted  (halted)
    );

    always #50 clock = ~clock;

    // unified memory with combinational read and write on the rising edge
    assign rdata = mem[address[7:0]];

    always @(posedge clock)
    begin
        if (rw === 1'b0)
        begin
            assert (address < mem_words)
            begin
                mem[address[7:0]] <= wdata;
                write_count <= write_count + 1;
            end
            else
            begin
                $display("store to address %h lies outside the memory", address);
                stop_run();
            end
        end
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        assert (cycles < cycle_limit)
        else
        begin
            $display("timeout: the CPU did not halt within %0d clock cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] time %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mem(input int addr, input logic [31:0] exp);
        check_value($sformatf("mem[%0d]", addr), mem[addr], exp);
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] addr);
        return {8'hee, addr, ~addr, addr};
    endfunction

    function automatic logic [31:0] asm_reg(input opcode_e op, input logic [reg_idx_w-1:0] rd,
                                            input logic [reg_idx_w-1:0] ra,
                                            input logic [reg_idx_w-1:0] rb);
        instr_t w;
        w = '0;
        w.r.opcode = op;
        w.r.rd = rd;
        w.r.ra = ra;
        w.r.rb = rb;
        return w;
    endfunction

    function automatic logic [31:0] asm_imm(input opcode_e op, input logic [reg_idx_w-1:0] rd,
                                            input logic [reg_idx_w-1:0] ra, input int imm);
        instr_t w;
        w = '0;
        w.i.opcode = op;
        w.i.rd = rd;
        w.i.ra = ra;
        w.i.imm = imm[imm_w-1:0];
        return w;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic load_program();
        for (int a = 0; a < mem_words; a++)
            mem[a] = (a < prog.size()) ? prog[a] : fill_word(a[7:0]);
    endtask

    // outputs are checked before the first edge after release
    task automatic pulse_reset();
        rst = 1'b1;
        repeat (reset_cycles) next_cycle();
        rst = 1'b0;
        #1;
        check_value("rw", rw, 1'b1);
        check_value("halted", halted, 1'b0);
        check_value("address", address, reset_pc);
    endtask

    task automatic run_program();
        load_program();
        pulse_reset();
        while (halted !== 1'b1)
            next_cycle();
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom & 32'h3ffff;
        b = $urandom & 32'h3ffff;
        prog = {};
        prog.push_back(asm_imm(op_addi, 1, 0, int'(a)));
        prog.push_back(asm_imm(op_addi, 2, 0, int'(b)));
        prog.push_back(asm_reg(op_add, 3, 1, 2));
        prog.push_back(asm_imm(op_store, 3, 0, 128));
        prog.push_back(asm_reg(op_sub, 4, 1, 2));
        prog.push_back(asm_imm(op_store, 4, 0, 129));
        prog.push_back(asm_reg(op_and, 5, 1, 2));
        prog.push_back(asm_imm(op_store, 5, 0, 130));
        prog.push_back(asm_reg(op_or, 6, 1, 2));
        prog.push_back(asm_imm(op_store, 6, 0, 131));
        prog.push_back(asm_reg(op_xor, 7, 1, 2));
        prog.push_back(asm_imm(op_store, 7, 0, 132));
        prog.push_back(asm_imm(op_store, 1, 0, 133));
        prog.push_back(asm_imm(op_store, 2, 0, 134));
        prog.push_back(asm_reg(op_halt, 0, 0, 0));
        run_program();
        check_mem(128, a + b);
        check_mem(129, a - b);
        check_mem(130, a & b);
        check_mem(131, a | b);
        check_mem(132, a ^ b);
        check_mem(133, a);
        check_mem(134, b);
    endtask

    task automatic test_flags_branch();
        logic [31:0] ones;
        logic [31:0] marker;
        logic [32:0] sum_big;
        logic [32:0] sum_small;
        logic [31:0] zero_res;
        ones      = 32'hffffffff;
        marker    = $urandom & 32'hffff;
        sum_big   = {1'b0, ones} + {1'b0, ones};
        sum_small = 33'd1 + 33'd1;
        zero_res  = ones ^ ones;
        prog = {};
        prog.push_back(asm_imm(op_addi, 1, 0, -1));
        prog.push_back(asm_imm(op_addi, 3, 0, int'(marker)));
        prog.push_back(asm_reg(op_add, 2, 1, 1));
        prog.push_back(asm_imm(op_bflag, 0, 2, 2));
        prog.push_back(asm_imm(op_store, 3, 0, 140));
        prog.push_back(asm_imm(op_addi, 4, 0, 1));
        prog.push_back(asm_reg(op_add, 5, 4, 4));
        prog.push_back(asm_imm(op_bflag, 0, 5, 2));
        prog.push_back(asm_imm(op_store, 3, 0, 141));
        prog.push_back(asm_reg(op_xor, 6, 1, 1));
        prog.push_back(asm_imm(op_bflag, 0, 6, 2));
        prog.push_back(asm_imm(op_store, 3, 0, 142));
        prog.push_back(asm_imm(op_store, 2, 0, 143));
        prog.push_back(asm_imm(op_store, 6, 0, 144));
        prog.push_back(asm_reg(op_halt, 0, 0, 0));
        run_program();
        // a taken branch skips its marker store
        check_mem(140, sum_big[32] ? fill_word(140) : marker);
        check_mem(141, sum_small[32] ? fill_word(141) : marker);
        check_mem(142, (zero_res == '0) ? fill_word(142) : marker);
        check_mem(143, sum_big[31:0]);
        check_mem(144, zero_res);
    endtask

    task automatic test_load_store();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] base;
        v1   = $urandom & 32'h3ffff;
        v2   = $urandom & 32'h3ffff;
        base = 32'd160;
        prog = {};
        prog.push_back(asm_imm(op_addi, 1, 0, int'(v1)));
        prog.push_back(asm_imm(op_addi, 2, 0, int'(v2)));
        prog.push_back(asm_imm(op_addi, 7, 0, int'(base)));
        prog.push_back(asm_imm(op_addi, 6, 0, 200));
        prog.push_back(asm_imm(op_store, 1, 7, 0));
        prog.push_back(asm_imm(op_store, 2, 7, 5));
        prog.push_back(asm_imm(op_store, 1, 6, -20));
        // zero results leave r4 and r5 flagged before the loads
        prog.push_back(asm_reg(op_xor, 4, 0, 0));
        prog.push_back(asm_reg(op_xor, 5, 0, 0));
        prog.push_back(asm_imm(op_load, 4, 7, 0));
        prog.push_back(asm_imm(op_load, 5, 7, 5));
        prog.push_back(asm_imm(op_load, 3, 6, -20));
        prog.push_back(asm_imm(op_store, 4, 7, 10));
        prog.push_back(asm_imm(op_store, 5, 7, 11));
        prog.push_back(asm_imm(op_store, 3, 7, 13));
        prog.push_back(asm_imm(op_bflag, 0, 4, 2));
        prog.push_back(asm_imm(op_store, 7, 0, 172));
        prog.push_back(asm_reg(op_halt, 0, 0, 0));
        run_program();
        check_mem(160, v1);
        check_mem(165, v2);
        check_mem(180, v1);
        check_mem(170, v1);
        check_mem(171, v2);
        check_mem(173, v1);
        // the load clears the r4 flag so the store at 172 runs
        check_mem(172, base);
    endtask

    task automatic test_jump_halt();
        logic [31:0] v;
        int          writes_at_halt;
        v = $urandom & 32'h3ffff;
        prog = {};
        prog.push_back(asm_imm(op_addi, 1, 0, int'(v)));
        prog.push_back(asm_imm(op_store, 1, 0, 190));
        prog.push_back(asm_imm(op_jump, 0, 0, 6));
        prog.push_back(asm_imm(op_store, 1, 0, 191));
        prog.push_back(asm_imm(op_store, 1, 0, 192));
        prog.push_back(asm_imm(op_store, 1, 0, 193));
        prog.push_back(asm_reg(op_halt, 0, 0, 0));
        run_program();
        writes_at_halt = write_count;
        check_mem(190, v);
        for (int a = 191; a <= 193; a++)
            check_mem(a, fill_word(a[7:0]));
        repeat (idle_cycles)
        begin
            next_cycle();
            check_value("halted", halted, 1'b1);
            check_value("write_count", write_count, writes_at_halt);
        end
    endtask

    initial
    begin
        clock = 1'b0;
        rst   = 1'b1;
        void'($urandom(rand_seed));
        next_cycle();
        test_alu_ops();
        test_flags_branch();
        test_load_store();
        test_jump_halt();
        $display("No errors");
        $finish;
    end

endmodule

/* files.f */
hw/cpu_isa_pkg.sv
hw/cpu_core_pkg.sv
hw/cpu_control.sv
hw/cpu_reg_file.sv
hw/cpu_alu.sv
hw/cpu_pc_unit.sv
hw/cpu_top.sv
verif/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - hw/cpu_isa_pkg.sv
  - hw/cpu_core_pkg.sv
  - hw/cpu_control.sv
  - hw/cpu_reg_file.sv
  - hw/cpu_alu.sv
  - hw/cpu_pc_unit.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - verif/cpu_tb.sv
